/* include/ifetch_settings.svh */
// Build-time settings for the instruction fetch subsystem
// Datapath widths, reset address, in-flight limit, memory geometry

`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// Datapath widths
`define IFETCH_ADDR_BITS      32
`define IFETCH_INST_BITS      32
`define IFETCH_EPOCH_BITS     4

// First fetch address out of reset
`define IFETCH_RESET_ADDR     32'h0000_0100

// Fetch side limit on outstanding reads
`define IFETCH_MAX_IN_FLIGHT  4

// Memory geometry, 256 words indexed by pc[9:2]
`define IFETCH_MEM_WORDS      256
`define IFETCH_MEM_LATENCY    2
`define IFETCH_QUEUE_DEPTH    4

`endif

/* design/ifetch_pkg.sv */
// Shared types for the instruction fetch subsystem
// Memory request opcode and response queue status

package ifetch_pkg;

  // ---------------------------------------------------------------------
  // Memory request opcode
  // ---------------------------------------------------------------------

  // Fetch only ever reads
  // Write is kept so the opcode field has a meaning on the bus
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  // ---------------------------------------------------------------------
  // Response queue status
  // ---------------------------------------------------------------------

  // Reported by resp_queue every cycle
  // Partial means at least one entry and at least one free slot
  typedef enum logic [1:0] {
    q_empty   = 2'd0,
    q_partial = 2'd1,
    q_full    = 2'd2
  } queue_state_e;

endpackage

/* design/resp_queue.sv */
// Response queue: circular buffer of read responses
// Holds addr, data and epoch until fetch takes them

`timescale 1ns/100ps

`include "ifetch_settings.svh"

module resp_queue (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        push,
  input  logic [`IFETCH_ADDR_BITS-1:0]                push_addr,
  input  logic [`IFETCH_INST_BITS-1:0]                push_data,
  input  logic [`IFETCH_EPOCH_BITS-1:0]               push_epoch,
  input  logic                                        pop,
  output logic                                        out_val,
  output logic [`IFETCH_ADDR_BITS-1:0]                out_addr,
  output logic [`IFETCH_INST_BITS-1:0]                out_data,
  output logic [`IFETCH_EPOCH_BITS-1:0]               out_epoch,
  output logic [$clog2(`IFETCH_QUEUE_DEPTH + 1)-1:0]  count,
  output ifetch_pkg::queue_state_e                    state
);

  localparam int DEPTH    = `IFETCH_QUEUE_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(DEPTH);

  logic [`IFETCH_ADDR_BITS-1:0]   buf_addr  [DEPTH];
  logic [`IFETCH_INST_BITS-1:0]   buf_data  [DEPTH];
  logic [`IFETCH_EPOCH_BITS-1:0]  buf_epoch [DEPTH];
  logic [PTR_BITS-1:0]            wr_ptr;
  logic [PTR_BITS-1:0]            rd_ptr;
  logic                           do_push;
  logic                           do_pop;

  // Guard against push when full and pop when empty
  assign do_push = push && (count != FULL_CNT);
  assign do_pop  = pop && (count != '0);

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      buf_addr[wr_ptr]  <= push_addr;
      buf_data[wr_ptr]  <= push_data;
      buf_epoch[wr_ptr] <= push_epoch;
    end
  end

  // Pointers wrap at DEPTH, not a power of two in general
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head of queue, straight from registers
  assign out_val   = (count != '0);
  assign out_addr  = buf_addr[rd_ptr];
  assign out_data  = buf_data[rd_ptr];
  assign out_epoch = buf_epoch[rd_ptr];

  always_comb begin
    if (count == '0) begin
      state = ifetch_pkg::q_empty;
    end else if (count == FULL_CNT) begin
      state = ifetch_pkg::q_full;
    end else begin
      state = ifetch_pkg::q_partial;
    end
  end

endmodule

/* design/fetch_unit.sv */
// Fetch unit with pc register, epoch tag and in-flight counter
// Redirect on squash, drop of stale responses, decode handshake

`timescale 1ns/100ps

`include "ifetch_settings.svh"

module fetch_unit (
  input  logic                           clk,
  input  logic                           rst,
  // Redirect from decode
  input  logic                           squash,
  input  logic [`IFETCH_ADDR_BITS-1:0]   branch_target,
  // Memory response
  input  logic                           resp_val,
  input  logic [`IFETCH_ADDR_BITS-1:0]   resp_addr,
  input  logic [`IFETCH_INST_BITS-1:0]   resp_data,
  input  logic [`IFETCH_EPOCH_BITS-1:0]  resp_epoch,
  output logic                           resp_rdy,
  // Memory request
  output logic                           req_val,
  input  logic                           req_rdy,
  output ifetch_pkg::mem_op_e            req_op,
  output logic [`IFETCH_ADDR_BITS-1:0]   req_addr,
  output logic [`IFETCH_EPOCH_BITS-1:0]  req_epoch,
  // Decode stage
  output logic                           d_val,
  input  logic                           d_rdy,
  output logic [`IFETCH_ADDR_BITS-1:0]   d_pc,
  output logic [`IFETCH_INST_BITS-1:0]   d_inst
);

  localparam int CNT_BITS = $clog2(`IFETCH_MAX_IN_FLIGHT + 1);
  localparam logic [CNT_BITS-1:0] MAX_L = CNT_BITS'(`IFETCH_MAX_IN_FLIGHT);
  localparam logic [`IFETCH_ADDR_BITS-1:0] WORD_STEP = `IFETCH_ADDR_BITS'(4);

  logic                           req_xfer;
  logic                           resp_xfer;
  logic [CNT_BITS-1:0]            in_flight;
  logic [`IFETCH_ADDR_BITS-1:0]   pc;
  logic [`IFETCH_EPOCH_BITS-1:0]  epoch;
  logic [`IFETCH_EPOCH_BITS-1:0]  epoch_next;
  logic                           drop;

  assign req_xfer  = req_val && req_rdy;
  assign resp_xfer = resp_val && resp_rdy;

  // ---------------------------------------------------------------------
  // Outstanding request count
  // ---------------------------------------------------------------------

  // Dropped responses still retire a slot
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({req_xfer, resp_xfer})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Independent of req_rdy
  // Low during reset
  assign req_val = !rst && (in_flight < MAX_L);

  // ---------------------------------------------------------------------
  // Program counter and epoch
  // ---------------------------------------------------------------------

  // Target goes out in the squash cycle itself
  assign req_addr = squash ? branch_target : pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `IFETCH_RESET_ADDR;
    end else if (req_xfer) begin
      // Squash case included since req_addr is then the target
      pc <= req_addr + WORD_STEP;
    end else if (squash) begin
      pc <= branch_target;
    end
  end

  assign epoch_next = epoch + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      epoch <= '0;
    end else if (squash) begin
      epoch <= epoch_next;
    end
  end

  // New epoch tags the redirected request right away
  assign req_epoch = squash ? epoch_next : epoch;
  assign req_op    = ifetch_pkg::mem_read;

  // ---------------------------------------------------------------------
  // Response path to decode
  // ---------------------------------------------------------------------

  // Old epoch or anything arriving alongside a squash
  assign drop = (resp_epoch != epoch) || squash;

  // Stale responses drain without waiting on decode
  assign resp_rdy = d_rdy || drop;
  assign d_val    = resp_val && !drop;
  assign d_pc     = resp_addr;
  assign d_inst   = resp_data;

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Counter must respect the limit across all cycles
  a_in_flight_limit : assert property (
    @(posedge clk) disable iff (rst)
    in_flight <= MAX_L
  ) else $error("fetch_unit: in-flight count above limit");

  // Held decode output stays put until taken or squashed
  a_decode_stable : assert property (
    @(posedge clk) disable iff (rst)
    (d_val && !d_rdy && !squash) ##1 !squash
      |-> d_val && $stable(d_pc) && $stable(d_inst)
  ) else $error("fetch_unit: decode output changed while stalled");

endmodule

/* design/imem.sv */
// Instruction memory: word array with load port
// Fixed-latency read pipeline, credit admission, response queue

`timescale 1ns/100ps

`include "ifetch_settings.svh"

module imem (
  input  logic                           clk,
  input  logic                           rst,
  // Request from fetch
  input  logic                           req_val,
  output logic                           req_rdy,
  input  ifetch_pkg::mem_op_e            req_op,
  input  logic [`IFETCH_ADDR_BITS-1:0]   req_addr,
  input  logic [`IFETCH_EPOCH_BITS-1:0]  req_epoch,
  // Response to fetch
  output logic                           resp_val,
  input  logic                           resp_rdy,
  output logic [`IFETCH_ADDR_BITS-1:0]   resp_addr,
  output logic [`IFETCH_INST_BITS-1:0]   resp_data,
  output logic [`IFETCH_EPOCH_BITS-1:0]  resp_epoch,
  // Preload port
  input  logic                           load_en,
  input  logic [`IFETCH_ADDR_BITS-1:0]   load_addr,
  input  logic [`IFETCH_INST_BITS-1:0]   load_data
);

  localparam int LAT      = `IFETCH_MEM_LATENCY;
  localparam int IDX_BITS = $clog2(`IFETCH_MEM_WORDS);
  localparam int CNT_BITS = $clog2(`IFETCH_QUEUE_DEPTH + 1);
  localparam int OCC_BITS = $clog2(`IFETCH_QUEUE_DEPTH + LAT + 1);
  localparam logic [OCC_BITS-1:0] DEPTH_L = OCC_BITS'(`IFETCH_QUEUE_DEPTH);

  logic [`IFETCH_INST_BITS-1:0]   mem_array [`IFETCH_MEM_WORDS];
  logic [IDX_BITS-1:0]            req_idx;
  logic [IDX_BITS-1:0]            load_idx;
  logic                           req_xfer;

  // Read pipeline, stage LAT-1 feeds the queue
  logic [LAT-1:0]                 pipe_val;
  logic [`IFETCH_ADDR_BITS-1:0]   pipe_addr  [LAT];
  logic [`IFETCH_INST_BITS-1:0]   pipe_data  [LAT];
  logic [`IFETCH_EPOCH_BITS-1:0]  pipe_epoch [LAT];

  logic [CNT_BITS-1:0]            q_count;
  ifetch_pkg::queue_state_e       q_state;
  logic [OCC_BITS-1:0]            occupancy;

  // Word index from the byte address
  assign req_idx  = req_addr[IDX_BITS+1:2];
  assign load_idx = load_addr[IDX_BITS+1:2];
  assign req_xfer = req_val && req_rdy;

  // ---------------------------------------------------------------------
  // Word array
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem_array[load_idx] <= load_data;
    end
  end

  // ---------------------------------------------------------------------
  // Read pipeline
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_val <= '0;
    end else begin
      pipe_val[0] <= req_xfer;
      for (int k = 1; k < LAT; k++) begin
        pipe_val[k] <= pipe_val[k-1];
      end
    end
  end

  // Array read happens in the accept cycle
  always_ff @(posedge clk) begin
    pipe_addr[0]  <= req_addr;
    pipe_data[0]  <= mem_array[req_idx];
    pipe_epoch[0] <= req_epoch;
    for (int k = 1; k < LAT; k++) begin
      pipe_addr[k]  <= pipe_addr[k-1];
      pipe_data[k]  <= pipe_data[k-1];
      pipe_epoch[k] <= pipe_epoch[k-1];
    end
  end

  // ---------------------------------------------------------------------
  // Admission
  // ---------------------------------------------------------------------

  // Every word in the pipe already owns a queue slot
  always_comb begin
    occupancy = OCC_BITS'(q_count);
    for (int k = 0; k < LAT; k++) begin
      occupancy = occupancy + OCC_BITS'(pipe_val[k]);
    end
  end

  // A pop in this cycle is not credited, keeps the path short
  assign req_rdy = (q_state != ifetch_pkg::q_full) && (occupancy < DEPTH_L);

  // ---------------------------------------------------------------------
  // Response queue
  // ---------------------------------------------------------------------

  resp_queue u_resp_queue (
    .clk        (clk),
    .rst        (rst),
    .push       (pipe_val[LAT-1]),
    .push_addr  (pipe_addr[LAT-1]),
    .push_data  (pipe_data[LAT-1]),
    .push_epoch (pipe_epoch[LAT-1]),
    .pop        (resp_rdy),
    .out_val    (resp_val),
    .out_addr   (resp_addr),
    .out_data   (resp_data),
    .out_epoch  (resp_epoch),
    .count      (q_count),
    .state      (q_state)
  );

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  a_read_only : assert property (
    @(posedge clk) disable iff (rst)
    req_xfer |-> req_op == ifetch_pkg::mem_read
  ) else $error("imem: non-read request accepted");

  // Credit scheme must hold LAT cycles after admission
  a_no_overflow : assert property (
    @(posedge clk) disable iff (rst)
    pipe_val[LAT-1] |-> q_state != ifetch_pkg::q_full
  ) else $error("imem: response queue pushed while full");

endmodule

/* design/ifetch_top.sv */
// Instruction fetch subsystem top level
// Fetch unit and instruction memory, decode and load ports

`timescale 1ns/100ps

`include "ifetch_settings.svh"

module ifetch_top (
  input  logic                          clk,
  input  logic                          rst,
  // Decode side
  input  logic                          squash,
  input  logic [`IFETCH_ADDR_BITS-1:0]  branch_target,
  output logic                          d_val,
  input  logic                          d_rdy,
  output logic [`IFETCH_ADDR_BITS-1:0]  d_pc,
  output logic [`IFETCH_INST_BITS-1:0]  d_inst,
  // Memory preload
  input  logic                          load_en,
  input  logic [`IFETCH_ADDR_BITS-1:0]  load_addr,
  input  logic [`IFETCH_INST_BITS-1:0]  load_data
);

  // ---------------------------------------------------------------------
  // Fetch to memory wires
  // ---------------------------------------------------------------------

  logic                           req_val;
  logic                           req_rdy;
  ifetch_pkg::mem_op_e            req_op;
  logic [`IFETCH_ADDR_BITS-1:0]   req_addr;
  logic [`IFETCH_EPOCH_BITS-1:0]  req_epoch;

  logic                           resp_val;
  logic                           resp_rdy;
  logic [`IFETCH_ADDR_BITS-1:0]   resp_addr;
  logic [`IFETCH_INST_BITS-1:0]   resp_data;
  logic [`IFETCH_EPOCH_BITS-1:0]  resp_epoch;

  fetch_unit u_fetch_unit (
    .clk           (clk),
    .rst           (rst),
    .squash        (squash),
    .branch_target (branch_target),
    .resp_val      (resp_val),
    .resp_addr     (resp_addr),
    .resp_data     (resp_data),
    .resp_epoch    (resp_epoch),
    .resp_rdy      (resp_rdy),
    .req_val       (req_val),
    .req_rdy       (req_rdy),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_epoch     (req_epoch),
    .d_val         (d_val),
    .d_rdy         (d_rdy),
    .d_pc          (d_pc),
    .d_inst        (d_inst)
  );

  imem u_imem (
    .clk        (clk),
    .rst        (rst),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_epoch  (req_epoch),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .resp_addr  (resp_addr),
    .resp_data  (resp_data),
    .resp_epoch (resp_epoch),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

endmodule

/* testbench/clk_gen.sv */
// Testbench clock source, 4 ns period

`timescale 1ns/100ps

module clk_gen (
  output logic clk
);

  // Half period of 2 ns
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

endmodule

/* testbench/tb_ifetch.sv */
// Testbench for ifetch_top with LCG memory image, load and stimulus phases
// Reference pc model with comparing process, check task, watchdog

`timescale 1ns/100ps

`include "ifetch_settings.svh"

module tb_ifetch;

  localparam logic [31:0] SEED = 32'd46276;
  // Transfers per phase summed for the watchdog
  localparam int TOTAL_XFERS  = 40 + 60 + 20 + 20 + 3 * 8 + 20;
  localparam int LOAD_CYCLES  = `IFETCH_MEM_WORDS + 8;
  localparam int WDOG_CYCLES  = TOTAL_XFERS * 20 + LOAD_CYCLES;

  logic                           clk;
  logic                           rst;
  logic                           squash;
  logic [`IFETCH_ADDR_BITS-1:0]   branch_target;
  logic                           d_rdy;
  logic                           d_val;
  logic [`IFETCH_ADDR_BITS-1:0]   d_pc;
  logic [`IFETCH_INST_BITS-1:0]   d_inst;
  logic                           load_en;
  logic [`IFETCH_ADDR_BITS-1:0]   load_addr;
  logic [`IFETCH_INST_BITS-1:0]   load_data;

  logic [31:0]                    rng_state;
  logic [`IFETCH_INST_BITS-1:0]   image [`IFETCH_MEM_WORDS];
  logic                           checking;
  int                             xfer_count;
  // Reference state
  logic [`IFETCH_ADDR_BITS-1:0]   exp_pc;
  logic                           held;
  logic [`IFETCH_ADDR_BITS-1:0]   held_pc;
  logic [`IFETCH_INST_BITS-1:0]   held_inst;

  clk_gen u_clk_gen (.clk(clk));

  ifetch_top u_ifetch_top (
    .clk           (clk),
    .rst           (rst),
    .squash        (squash),
    .branch_target (branch_target),
    .d_val         (d_val),
    .d_rdy         (d_rdy),
    .d_pc          (d_pc),
    .d_inst        (d_inst),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data)
  );

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------

  function automatic logic [31:0] lcg_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Image word for a byte address with word index in pc[9:2]
  function automatic logic [`IFETCH_INST_BITS-1:0] expected_inst(
    input logic [`IFETCH_ADDR_BITS-1:0] pc
  );
    return image[pc[9:2]];
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Inputs change 0.5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) next_cycle();
    rst = 1'b0;
  endtask

  task automatic load_image();
    load_en = 1'b1;
    for (int i = 0; i < `IFETCH_MEM_WORDS; i++) begin
      load_addr = `IFETCH_ADDR_BITS'(i) << 2;
      load_data = image[i];
      next_cycle();
    end
    load_en = 1'b0;
  endtask

  task automatic wait_xfers(input int n);
    int target;
    target = xfer_count + n;
    while (xfer_count < target) next_cycle();
  endtask

  // Top LCG bit gives about half of the cycles ready
  task automatic random_rdy_xfers(input int n);
    int target;
    logic [31:0] r;
    target = xfer_count + n;
    while (xfer_count < target) begin
      r = lcg_rand();
      d_rdy = r[31];
      next_cycle();
    end
  endtask

  // Squash held n cycles with a fresh aligned target each cycle
  task automatic squash_run(input int n);
    for (int i = 0; i < n; i++) begin
      squash = 1'b1;
      branch_target = lcg_rand() & ~32'h3;
      next_cycle();
    end
    squash = 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // Comparing process
  // ---------------------------------------------------------------------

  // Samples pre-edge values
  // Redirect wins over a transfer
  always @(posedge clk) begin
    if (rst || !checking) begin
      exp_pc = `IFETCH_RESET_ADDR;
      held   = 1'b0;
    end else begin
      if (held && !squash) begin
        check_equal("d_val while stalled", 32'(d_val), 32'd1);
        check_equal("d_pc while stalled", d_pc, held_pc);
        check_equal("d_inst while stalled", d_inst, held_inst);
      end
      if (squash) begin
        exp_pc = branch_target;
      end else if (d_val && d_rdy) begin
        check_equal("d_pc", d_pc, exp_pc);
        check_equal("d_inst", d_inst, expected_inst(exp_pc));
        exp_pc = exp_pc + 32'd4;
        xfer_count = xfer_count + 1;
      end
      held      = d_val && !d_rdy && !squash;
      held_pc   = d_pc;
      held_inst = d_inst;
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------

  initial begin
    rst           = 1'b1;
    squash        = 1'b0;
    branch_target = '0;
    d_rdy         = 1'b0;
    load_en       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    checking      = 1'b0;
    xfer_count    = 0;
    rng_state     = SEED;
    for (int i = 0; i < `IFETCH_MEM_WORDS; i++) begin
      image[i] = lcg_rand();
    end

    // Decode held off while the array fills
    // Second reset gives a clean start
    apply_reset();
    load_image();
    apply_reset();
    checking = 1'b1;

    // Straight stream from the reset address
    d_rdy = 1'b1;
    wait_xfers(40);

    // Random back-pressure
    random_rdy_xfers(60);

    // Single redirect
    d_rdy = 1'b1;
    squash_run(1);
    wait_xfers(20);

    // Back-to-back redirects where the newest target must win
    squash_run(2);
    wait_xfers(20);

    // Redirects while decode stalls
    for (int r = 0; r < 3; r++) begin
      d_rdy = 1'b0;
      repeat (5 + r) next_cycle();
      squash_run(1 + (r % 2));
      random_rdy_xfers(8);
    end

    // Long stall keeps the next word waiting at the head
    d_rdy = 1'b0;
    repeat (30) next_cycle();
    check_equal("d_val after stall", 32'(d_val), 32'd1);
    check_equal("d_pc after stall", d_pc, exp_pc);
    d_rdy = 1'b1;
    wait_xfers(20);

    $display("Simulation PASSED");
    $finish;
  end

  // ---------------------------------------------------------------------
  // Watchdog
  // ---------------------------------------------------------------------

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Watchdog timeout after %0d cycles, %0d of %0d decode transfers seen",
             WDOG_CYCLES, xfer_count, TOTAL_XFERS);
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

/* ifetch_sys.f */
+incdir+include
design/ifetch_pkg.sv
design/resp_queue.sv
design/fetch_unit.sv
design/imem.sv
design/ifetch_top.sv
testbench/clk_gen.sv
testbench/tb_ifetch.sv

/* Makefile */
# Verilator build and run for the instruction fetch subsystem

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_ifetch, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 \
	  --top-module tb_ifetch -f ifetch_sys.f -Mdir obj_dir
	./obj_dir/Vtb_ifetch | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || \
	  (echo "test: pass line missing from $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
